// File: source/exceptionPkg.sv
package exceptionPkg;

    // Cause register width
    // Bits 7 and up read back as zero
    localparam int causeWidth = 32;

    // Register index width
    // Top index bit selects the class
    // 0 to 15 real, 16 to 31 imaginary
    localparam int regIndexWidth = 5;

    // Cause bit positions in the cause register

    // Load of a real value into an imaginary register or the reverse
    localparam int causeRealImagLoad = 0;

    // Arithmetic that mixes a real and an imaginary register
    localparam int causeComplexArith = 1;

    // Read of FFT output while the accelerator is still running
    localparam int causeFftNotComplete = 2;

    // Read of an address outside data memory
    localparam int causeMemAccess = 3;

    // Write outside data memory or into the FFT output region
    localparam int causeMemWrite = 4;

    // Jump past the end of program memory
    localparam int causeInvalidJump = 5;

    // Filter start with no filter loaded
    localparam int causeInvalidFilter = 6;

endpackage

// File: source/memoryGuard.sv
`timescale 1ns/1ps

module memoryGuard #(
    parameter int unsigned addrWidth   = 16,
    parameter int unsigned dataMemSize = 4096,
    parameter int unsigned fftOutBase  = 3072,
    parameter int unsigned fftOutSize  = 512,
    parameter int unsigned fftLatency  = 64
) (
    // Clock and reset
    input  logic                 clk,
    input  logic                 rstN,
    // Memory access strobes
    input  logic                 memRead,
    input  logic                 memWrite,
    input  logic [addrWidth-1:0] memAddr,
    // FFT accelerator start
    input  logic                 fftStart,
    // Raise levels
    output logic                 memAccessEx,
    output logic                 memWriteEx,
    output logic                 fftNotCompleteEx
);

    // Counter needs to hold the full latency value
    localparam int cntWidth = $clog2(fftLatency + 1);

    // First address past the FFT output region
    localparam int unsigned fftOutEnd = fftOutBase + fftOutSize;

    // Remaining busy cycles of the FFT, zero when idle
    logic [cntWidth-1:0] fftBusyCnt;
    logic                fftBusy;

    // Address decode
    logic outOfRange;
    logic inFftRegion;

    // FFT busy window
    // A start loads the full latency, so the busy cycles begin right after it
    // A start while busy reloads and restarts the window
    always_ff @(posedge clk) begin
        if (!rstN) begin
            fftBusyCnt <= '0;
        end else if (fftStart) begin
            fftBusyCnt <= cntWidth'(fftLatency);
        end else if (fftBusy) begin
            fftBusyCnt <= fftBusyCnt - cntWidth'(1);
        end
    end

    assign fftBusy = (fftBusyCnt != '0);

    // Legal data addresses run from 0 to dataMemSize - 1
    assign outOfRange = (memAddr >= dataMemSize);

    // FFT output region is read only
    assign inFftRegion = (memAddr >= fftOutBase) && (memAddr < fftOutEnd);

    always_comb begin
        // Illegal read address
        memAccessEx = memRead && outOfRange;

        // Illegal write address or write into FFT output
        memWriteEx = memWrite && (outOfRange || inFftRegion);

        // FFT result read before the accelerator finishes
        // The start cycle itself is not yet busy
        fftNotCompleteEx = memRead && inFftRegion && fftBusy;
    end

endmodule

// File: source/operandClassChecker.sv
`timescale 1ns/1ps

module operandClassChecker import exceptionPkg::*; #(
    parameter int unsigned addrWidth = 16,
    parameter int unsigned imagBase  = 2048
) (
    // Register load from data memory
    input  logic                     loadValid,
    input  logic [regIndexWidth-1:0] loadReg,
    input  logic [addrWidth-1:0]     loadAddr,
    // Complex arithmetic operands
    input  logic                     arithValid,
    input  logic [regIndexWidth-1:0] arithSrcA,
    input  logic [regIndexWidth-1:0] arithSrcB,
    // Raise levels
    output logic                     realImagLoadEx,
    output logic                     complexArithmeticEx
);

    // Class flags, high means imaginary
    logic loadAddrImag;
    logic loadRegImag;
    logic srcAImag;
    logic srcBImag;

    // Data memory above imagBase holds imaginary values
    assign loadAddrImag = (loadAddr >= imagBase);

    // Register class sits in the index msb
    assign loadRegImag = loadReg[regIndexWidth-1];
    assign srcAImag    = arithSrcA[regIndexWidth-1];
    assign srcBImag    = arithSrcB[regIndexWidth-1];

    always_comb begin
        // Load crosses classes
        realImagLoadEx = loadValid && (loadAddrImag != loadRegImag);

        // Arithmetic mixes a real and an imaginary operand
        complexArithmeticEx = arithValid && (srcAImag != srcBImag);
    end

endmodule

// File: source/controlFlowChecker.sv
`timescale 1ns/1ps

module controlFlowChecker #(
    parameter int unsigned addrWidth = 16,
    parameter int unsigned progSize  = 1024
) (
    // Clock and reset
    input  logic                 clk,
    input  logic                 rstN,
    // Jump strobe and target address
    input  logic                 jumpValid,
    input  logic [addrWidth-1:0] jumpTarget,
    // Filter engine commands
    input  logic                 filterLoad,
    input  logic                 filterStart,
    // Raise levels
    output logic                 invalidJMPEx,
    output logic                 invalidFilterEx
);

    // Set once coefficients have been loaded
    // Only reset brings it back down
    logic filterLoaded;

    // Jump decode
    logic jumpOutOfRange;

    // Loaded state takes effect from the cycle after the load
    always_ff @(posedge clk) begin
        if (!rstN) begin
            filterLoaded <= 1'b0;
        end else if (filterLoad) begin
            filterLoaded <= 1'b1;
        end
    end

    // Legal targets run from 0 to progSize - 1
    assign jumpOutOfRange = (jumpTarget >= progSize);

    always_comb begin
        // Jump beyond program memory
        invalidJMPEx = jumpValid && jumpOutOfRange;

        // Start with nothing loaded
        // A load in the same cycle does not help, it counts as coming after
        invalidFilterEx = filterStart && !filterLoaded;
    end

endmodule

// File: source/exceptionController.sv
`timescale 1ns/1ps

module exceptionController import exceptionPkg::*; (
    // Clock and reset
    input  logic                  clk,
    input  logic                  rstN,
    // Raise levels from the checkers
    input  logic                  realImagLoadEx,
    input  logic                  complexArithmeticEx,
    input  logic                  fftNotCompleteEx,
    input  logic                  memAccessEx,
    input  logic                  memWriteEx,
    input  logic                  invalidJMPEx,
    input  logic                  invalidFilterEx,
    // Handler acknowledge
    input  logic                  clear,
    // Status to the core
    output logic [causeWidth-1:0] causeDataOut,
    output logic                  exception,
    output logic                  err
);

    // Raises mapped onto their cause bits
    logic [causeWidth-1:0] raiseVec;
    logic                  anyRaise;

    // Cause register and double fault flag
    logic [causeWidth-1:0] causeReg;
    logic                  errReg;

    // Every raise in a cycle lands in the vector
    // Unused upper bits stay zero
    always_comb begin
        raiseVec                      = '0;
        raiseVec[causeRealImagLoad]   = realImagLoadEx;
        raiseVec[causeComplexArith]   = complexArithmeticEx;
        raiseVec[causeFftNotComplete] = fftNotCompleteEx;
        raiseVec[causeMemAccess]      = memAccessEx;
        raiseVec[causeMemWrite]       = memWriteEx;
        raiseVec[causeInvalidJump]    = invalidJMPEx;
        raiseVec[causeInvalidFilter]  = invalidFilterEx;
    end

    assign anyRaise = |raiseVec;

    // Cause bits are sticky until the handler clears them
    // Clear beats any raise in the same cycle
    always_ff @(posedge clk) begin
        if (!rstN) begin
            causeReg <= '0;
        end else if (clear) begin
            causeReg <= '0;
        end else begin
            causeReg <= causeReg | raiseVec;
        end
    end

    // Double fault when a new raise meets an exception already held
    always_ff @(posedge clk) begin
        if (!rstN) begin
            errReg <= 1'b0;
        end else if (clear) begin
            errReg <= 1'b0;
        end else if (anyRaise && exception) begin
            errReg <= 1'b1;
        end
    end

    assign causeDataOut = causeReg;

    // Core halts while any cause is held
    assign exception = |causeReg;
    assign err       = errReg;

endmodule

// File: source/exceptionUnit.sv
`timescale 1ns/1ps

module exceptionUnit import exceptionPkg::*; #(
    parameter int unsigned addrWidth   = 16,
    parameter int unsigned dataMemSize = 4096,
    parameter int unsigned imagBase    = 2048,
    parameter int unsigned fftOutBase  = 3072,
    parameter int unsigned fftOutSize  = 512,
    parameter int unsigned fftLatency  = 64,
    parameter int unsigned progSize    = 1024
) (
    // Clock and reset
    input  logic                     clk,
    input  logic                     rstN,
    // Register load events
    input  logic                     loadValid,
    input  logic [regIndexWidth-1:0] loadReg,
    input  logic [addrWidth-1:0]     loadAddr,
    // Complex arithmetic events
    input  logic                     arithValid,
    input  logic [regIndexWidth-1:0] arithSrcA,
    input  logic [regIndexWidth-1:0] arithSrcB,
    // Memory events
    input  logic                     memRead,
    input  logic                     memWrite,
    input  logic [addrWidth-1:0]     memAddr,
    // Accelerator and control flow events
    input  logic                     fftStart,
    input  logic                     jumpValid,
    input  logic [addrWidth-1:0]     jumpTarget,
    input  logic                     filterLoad,
    input  logic                     filterStart,
    // Exception handler acknowledge
    input  logic                     clear,
    // Status
    output logic [causeWidth-1:0]    causeDataOut,
    output logic                     exception,
    output logic                     err
);

    // Raise levels into the controller
    logic realImagLoadEx;
    logic complexArithmeticEx;
    logic fftNotCompleteEx;
    logic memAccessEx;
    logic memWriteEx;
    logic invalidJMPEx;
    logic invalidFilterEx;

    // Memory map and FFT busy window
    memoryGuard #(
        .addrWidth  (addrWidth),
        .dataMemSize(dataMemSize),
        .fftOutBase (fftOutBase),
        .fftOutSize (fftOutSize),
        .fftLatency (fftLatency)
    ) iMemoryGuard (
        .clk             (clk),
        .rstN            (rstN),
        .memRead         (memRead),
        .memWrite        (memWrite),
        .memAddr         (memAddr),
        .fftStart        (fftStart),
        .memAccessEx     (memAccessEx),
        .memWriteEx      (memWriteEx),
        .fftNotCompleteEx(fftNotCompleteEx)
    );

    // Real and imaginary register classes
    operandClassChecker #(
        .addrWidth(addrWidth),
        .imagBase (imagBase)
    ) iOperandClassChecker (
        .loadValid          (loadValid),
        .loadReg            (loadReg),
        .loadAddr           (loadAddr),
        .arithValid         (arithValid),
        .arithSrcA          (arithSrcA),
        .arithSrcB          (arithSrcB),
        .realImagLoadEx     (realImagLoadEx),
        .complexArithmeticEx(complexArithmeticEx)
    );

    // Jumps and filter command order
    controlFlowChecker #(
        .addrWidth(addrWidth),
        .progSize (progSize)
    ) iControlFlowChecker (
        .clk            (clk),
        .rstN           (rstN),
        .jumpValid      (jumpValid),
        .jumpTarget     (jumpTarget),
        .filterLoad     (filterLoad),
        .filterStart    (filterStart),
        .invalidJMPEx   (invalidJMPEx),
        .invalidFilterEx(invalidFilterEx)
    );

    // Cause register, exception and double fault
    exceptionController iExceptionController (
        .clk                (clk),
        .rstN               (rstN),
        .realImagLoadEx     (realImagLoadEx),
        .complexArithmeticEx(complexArithmeticEx),
        .fftNotCompleteEx   (fftNotCompleteEx),
        .memAccessEx        (memAccessEx),
        .memWriteEx         (memWriteEx),
        .invalidJMPEx       (invalidJMPEx),
        .invalidFilterEx    (invalidFilterEx),
        .clear              (clear),
        .causeDataOut       (causeDataOut),
        .exception          (exception),
        .err                (err)
    );

endmodule

// File: verification/clockGen.sv
`timescale 1ns/1ps

module clockGen #(
    parameter int periodNs    = 40,
    parameter int resetCycles = 8
) (
    output logic clk,
    output logic rstN
);

    // Free running clock, starts low
    initial begin
        clk = 1'b0;
        forever #(periodNs / 2) clk = ~clk;
    end

    // Reset held over the first rising edges, released on a falling edge
    initial begin
        rstN = 1'b0;
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
    end

endmodule

// File: verification/exceptionUnitTb.sv
`timescale 1ns/1ps

module exceptionUnitTb import exceptionPkg::*; ();

    // Smaller memory map than the RTL defaults
    localparam int addrWidth   = 12;
    localparam int dataMemSize = 2000;
    localparam int imagBase    = 1000;
    localparam int fftOutBase  = 1500;
    localparam int fftOutSize  = 200;
    localparam int fftOutEnd   = fftOutBase + fftOutSize;
    localparam int fftLatency  = 10;
    localparam int progSize    = 300;

    // Run length in cycles, sets the watchdog limit
    localparam int resetCycles    = 8;
    localparam int directedCycles = 150;
    localparam int randomCycles   = 1500;
    localparam int timeoutNs = (resetCycles + directedCycles + randomCycles) * 40 + 4000;

    logic clk;
    logic rstN;
    // Event strobes and their data
    logic loadValid, arithValid, memRead, memWrite, fftStart;
    logic jumpValid, filterLoad, filterStart, clear;
    logic [regIndexWidth-1:0] loadReg, arithSrcA, arithSrcB;
    logic [addrWidth-1:0] loadAddr, memAddr, jumpTarget;
    // DUT status
    logic [causeWidth-1:0] causeDataOut;
    logic exception;
    logic err;

    // Reference model state
    logic [causeWidth-1:0] expCause;
    logic expErr;
    int fftBusyLeft;
    logic filterLoadedModel;

    // Boundaries that random addresses cluster around
    int addrEdges[5] = '{dataMemSize, imagBase, fftOutBase, fftOutEnd, progSize};

    clockGen #(.periodNs(40), .resetCycles(resetCycles)) clockSource (.clk(clk), .rstN(rstN));

    exceptionUnit #(
        .addrWidth  (addrWidth),
        .dataMemSize(dataMemSize),
        .imagBase   (imagBase),
        .fftOutBase (fftOutBase),
        .fftOutSize (fftOutSize),
        .fftLatency (fftLatency),
        .progSize   (progSize)
    ) dut (.*);

    // Expected state after the current rising edge
    function automatic void predictOutputs();
        logic [causeWidth-1:0] raises;
        logic inRegion;
        raises = '0;
        inRegion = (memAddr >= fftOutBase) && (memAddr < fftOutEnd);
        // Register class is imaginary from index 16 up
        raises[causeRealImagLoad] = loadValid && ((loadAddr >= imagBase) != (loadReg >= 16));
        raises[causeComplexArith] = arithValid && ((arithSrcA >= 16) != (arithSrcB >= 16));
        raises[causeFftNotComplete] = memRead && inRegion && (fftBusyLeft > 0);
        raises[causeMemAccess] = memRead && (memAddr >= dataMemSize);
        raises[causeMemWrite] = memWrite && ((memAddr >= dataMemSize) || inRegion);
        raises[causeInvalidJump] = jumpValid && (jumpTarget >= progSize);
        raises[causeInvalidFilter] = filterStart && !filterLoadedModel;
        if (!rstN) begin
            expCause = '0;
            expErr = 1'b0;
            fftBusyLeft = 0;
            filterLoadedModel = 1'b0;
        end else begin
            if (clear) begin
                expCause = '0;
                expErr = 1'b0;
            end else begin
                // Double fault needs a cause already held
                if ((raises != '0) && (expCause != '0)) expErr = 1'b1;
                expCause = expCause | raises;
            end
            // Busy for the fftLatency cycles after a start, restart reloads
            if (fftStart) begin
                fftBusyLeft = fftLatency;
            end else if (fftBusyLeft > 0) begin
                fftBusyLeft = fftBusyLeft - 1;
            end
            if (filterLoad) filterLoadedModel = 1'b1;
        end
    endfunction

    task automatic compareValue(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, actual,
                     expected);
            $display("TESTS FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // Model and DUT move on the same edge, outputs compared once settled
    always @(posedge clk) begin
        predictOutputs();
        #1;
        compareValue("causeDataOut", causeDataOut, expCause);
        compareValue("exception", exception, expCause != '0);
        compareValue("err", err, expErr);
    end

    initial begin
        #(timeoutNs);
        $display("Run timed out after %0d ns without reaching the end", timeoutNs);
        $display("TESTS FAILED");
        $fatal(1, "Watchdog expired");
    end

    function automatic logic [causeWidth-1:0] causeMask(input int pos);
        return causeWidth'(1) << pos;
    endfunction

    // Random address, often within one of a boundary
    function automatic logic [addrWidth-1:0] pickAddr();
        int sel;
        int addr;
        sel = $urandom_range(0, 6);
        if (sel < 5) begin
            addr = addrEdges[sel] + $urandom_range(0, 2) - 1;
        end else begin
            addr = $urandom_range(0, (1 << addrWidth) - 1);
        end
        return addr[addrWidth-1:0];
    endfunction

    task automatic setIdle();
        {loadValid, arithValid, memRead, memWrite, fftStart} = '0;
        {jumpValid, filterLoad, filterStart, clear} = '0;
        {loadReg, arithSrcA, arithSrcB, loadAddr, memAddr, jumpTarget} = '0;
    endtask

    // Driven events take one rising edge, then inputs go idle
    task automatic step();
        @(negedge clk);
        setIdle();
    endtask

    // Direct check of the held state
    task automatic expectHeld(input logic [causeWidth-1:0] bits, input logic errBit);
        compareValue("causeDataOut", causeDataOut, bits);
        compareValue("exception", exception, bits != '0);
        compareValue("err", err, errBit);
    endtask

    // One event cycle, its check, then a clear if anything got raised
    task automatic checkSingle(input logic [causeWidth-1:0] bits);
        step();
        expectHeld(bits, 1'b0);
        if (bits != '0) begin
            clear = 1'b1;
            step();
            expectHeld('0, 1'b0);
        end
    endtask

    initial begin
        void'($urandom(60106));
        setIdle();
        @(posedge rstN);
        expectHeld('0, 1'b0);

        // Load class against address class around imagBase
        {loadValid, loadReg, loadAddr} = {1'b1, 5'd3, addrWidth'(imagBase)};
        checkSingle(causeMask(causeRealImagLoad));
        {loadValid, loadReg, loadAddr} = {1'b1, 5'd20, addrWidth'(imagBase - 1)};
        checkSingle(causeMask(causeRealImagLoad));
        {loadValid, loadReg, loadAddr} = {1'b1, 5'd15, addrWidth'(imagBase - 1)};
        checkSingle('0);
        {loadValid, loadReg, loadAddr} = {1'b1, 5'd16, addrWidth'(imagBase)};
        checkSingle('0);
        {arithValid, arithSrcA, arithSrcB} = {1'b1, 5'd15, 5'd16};
        checkSingle(causeMask(causeComplexArith));
        {arithValid, arithSrcA, arithSrcB} = {1'b1, 5'd0, 5'd15};
        checkSingle('0);
        // Read and write limits of data memory and the FFT output region
        {memRead, memAddr} = {1'b1, addrWidth'(dataMemSize)};
        checkSingle(causeMask(causeMemAccess));
        {memRead, memAddr} = {1'b1, addrWidth'(dataMemSize - 1)};
        checkSingle('0);
        {memWrite, memAddr} = {1'b1, addrWidth'(dataMemSize)};
        checkSingle(causeMask(causeMemWrite));
        {memWrite, memAddr} = {1'b1, addrWidth'(fftOutBase)};
        checkSingle(causeMask(causeMemWrite));
        {memWrite, memAddr} = {1'b1, addrWidth'(fftOutEnd - 1)};
        checkSingle(causeMask(causeMemWrite));
        {memWrite, memAddr} = {1'b1, addrWidth'(fftOutBase - 1)};
        checkSingle('0);
        {memWrite, memAddr} = {1'b1, addrWidth'(fftOutEnd)};
        checkSingle('0);
        {jumpValid, jumpTarget} = {1'b1, addrWidth'(progSize)};
        checkSingle(causeMask(causeInvalidJump));
        {jumpValid, jumpTarget} = {1'b1, addrWidth'(progSize - 1)};
        checkSingle('0);
        // Start before any load, then load and start together still count as unloaded
        filterStart = 1'b1;
        checkSingle(causeMask(causeInvalidFilter));
        {filterLoad, filterStart} = 2'b11;
        checkSingle(causeMask(causeInvalidFilter));
        filterStart = 1'b1;
        checkSingle('0);

        // Several causes in one cycle
        {loadValid, loadReg, loadAddr} = {1'b1, 5'd3, addrWidth'(imagBase)};
        {arithValid, arithSrcA, arithSrcB} = {1'b1, 5'd0, 5'd31};
        {memRead, memWrite, memAddr} = {2'b11, addrWidth'(dataMemSize)};
        {jumpValid, jumpTarget} = {1'b1, addrWidth'(progSize + 5)};
        checkSingle(causeMask(causeRealImagLoad) | causeMask(causeComplexArith) |
                    causeMask(causeMemAccess) | causeMask(causeMemWrite) |
                    causeMask(causeInvalidJump));

        // Double fault, a new cause and a repeat of a held one
        {jumpValid, jumpTarget} = {1'b1, addrWidth'(progSize)};
        step();
        {arithValid, arithSrcA, arithSrcB} = {1'b1, 5'd1, 5'd17};
        step();
        expectHeld(causeMask(causeInvalidJump) | causeMask(causeComplexArith), 1'b1);
        clear = 1'b1;
        step();
        {jumpValid, jumpTarget} = {1'b1, addrWidth'(progSize)};
        step();
        {jumpValid, jumpTarget} = {1'b1, addrWidth'(progSize)};
        step();
        expectHeld(causeMask(causeInvalidJump), 1'b1);
        // Clear wins over a raise in the same cycle
        {clear, jumpValid, jumpTarget} = {2'b11, addrWidth'(progSize)};
        checkSingle('0);

        // FFT start with a read in the same cycle sees an idle FFT
        {fftStart, memRead, memAddr} = {2'b11, addrWidth'(fftOutBase)};
        checkSingle('0);
        // First busy cycle, then the last one
        {memRead, memAddr} = {1'b1, addrWidth'(fftOutBase + 1)};
        checkSingle(causeMask(causeFftNotComplete));
        repeat (fftLatency - 3) step();
        {memRead, memAddr} = {1'b1, addrWidth'(fftOutEnd - 1)};
        checkSingle(causeMask(causeFftNotComplete));
        // First cycle after a fresh window
        fftStart = 1'b1;
        step();
        repeat (fftLatency) step();
        {memRead, memAddr} = {1'b1, addrWidth'(fftOutBase)};
        checkSingle('0);
        // Restart extends the window to the new start
        fftStart = 1'b1;
        step();
        repeat (4) step();
        fftStart = 1'b1;
        step();
        repeat (fftLatency - 1) step();
        {memRead, memAddr} = {1'b1, addrWidth'(fftOutBase)};
        checkSingle(causeMask(causeFftNotComplete));

        // Random mix, checked by the comparing process
        for (int i = 0; i < randomCycles; i++) begin
            loadValid = ($urandom_range(0, 3) == 0);
            loadReg = $urandom_range(0, 31);
            loadAddr = pickAddr();
            arithValid = ($urandom_range(0, 3) == 0);
            arithSrcA = $urandom_range(0, 31);
            arithSrcB = $urandom_range(0, 31);
            memRead = ($urandom_range(0, 2) == 0);
            memWrite = ($urandom_range(0, 5) == 0);
            memAddr = pickAddr();
            fftStart = ($urandom_range(0, 15) == 0);
            jumpValid = ($urandom_range(0, 4) == 0);
            jumpTarget = pickAddr();
            filterLoad = ($urandom_range(0, 63) == 0);
            filterStart = ($urandom_range(0, 7) == 0);
            clear = ($urandom_range(0, 5) == 0);
            step();
        end

        repeat (2) step();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: sources.f
source/exceptionPkg.sv
source/memoryGuard.sv
source/operandClassChecker.sv
source/controlFlowChecker.sv
source/exceptionController.sv
source/exceptionUnit.sv
verification/clockGen.sv
verification/exceptionUnitTb.sv

// File: Bender.yml
package:
  name: exception_unit

sources:
  # Design, package first
  - files:
      - source/exceptionPkg.sv
      - source/memoryGuard.sv
      - source/operandClassChecker.sv
      - source/controlFlowChecker.sv
      - source/exceptionController.sv
      - source/exceptionUnit.sv
  # Testbench
  - target: test
    files:
      - verification/clockGen.sv
      - verification/exceptionUnitTb.sv
